//--- hdl/async_fifo.sv
`timescale 1ns/1ns

module async_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int FIFO_DEPTH = 16,
  parameter int RST_AFULL  = FIFO_DEPTH - 2,
  parameter int RST_AEMPTY = 2
) (
  input  logic                        wr_clk,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        wr_en,
  input  logic [DATA_WIDTH-1:0]       wr_data,
  input  fifo_cfg_pkg::cfg_write_t    cfg,
  input  logic                        rd_en,
  output logic [DATA_WIDTH-1:0]       rd_data,
  output logic                        rd_valid,
  output fifo_status_pkg::wr_status_t wr_status,
  output fifo_status_pkg::rd_status_t rd_status
);

  import fifo_cfg_pkg::*;

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  wr_rst_n;
  logic                  rd_rst_n_sync;
  logic                  ram_wen;
  logic                  ram_ren;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic [ADDR_WIDTH:0]   rd_gray;
  logic [ADDR_WIDTH:0]   wr_bin_sync;
  logic [ADDR_WIDTH:0]   rd_bin_sync;
  logic [LEVEL_W-1:0]    afull_level;
  logic [LEVEL_W-1:0]    aempty_level;

  fifo_wr_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_wr_ctrl (
    .wr_clk     (wr_clk),
    .rd_rst_n   (rd_rst_n),
    .wr_en      (wr_en),
    .rd_bin_sync(rd_bin_sync),
    .afull_level(afull_level),
    .wr_rst_n   (wr_rst_n),
    .ram_wen    (ram_wen),
    .wr_addr    (wr_addr),
    .wr_gray    (wr_gray),
    .wr_status  (wr_status)
  );

  fifo_rd_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_bin_sync  (wr_bin_sync),
    .aempty_level (aempty_level),
    .rd_rst_n_sync(rd_rst_n_sync),
    .ram_ren      (ram_ren),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .rd_valid     (rd_valid),
    .rd_status    (rd_status)
  );

  // write pointer into the read domain
  ptr_sync #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_wr2rd_sync (
    .dst_clk  (rd_clk),
    .dst_rst_n(rd_rst_n_sync),
    .gray_in  (wr_gray),
    .gray_sync(),
    .bin_sync (wr_bin_sync)
  );

  // read pointer into the write domain
  ptr_sync #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_rd2wr_sync (
    .dst_clk  (wr_clk),
    .dst_rst_n(wr_rst_n),
    .gray_in  (rd_gray),
    .gray_sync(),
    .bin_sync (rd_bin_sync)
  );

  dual_port_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram (
    .wr_clk (wr_clk),
    .wr_en  (ram_wen),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_clk (rd_clk),
    .rd_en  (ram_ren),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  fifo_thresh_regs #(
    .RST_AFULL (RST_AFULL),
    .RST_AEMPTY(RST_AEMPTY)
  ) u_thresh_regs (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .cfg         (cfg),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n_sync),
    .afull_level (afull_level),
    .aempty_level(aempty_level)
  );

endmodule

//--- hdl/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // rd_data holds its last word between accepted reads
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- hdl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

  // fill levels and thresholds share one width, enough for depths up to 128
  localparam int LEVEL_W = 8;

  // selects which threshold a configuration write lands in
  typedef enum logic [0:0] {
    CFG_AFULL_LEVEL  = 1'b0,
    CFG_AEMPTY_LEVEL = 1'b1
  } cfg_reg_e;

  // one configuration access from the writer, wen is a single-cycle strobe
  typedef struct packed {
    logic               wen;
    cfg_reg_e           sel;
    logic [LEVEL_W-1:0] value;
  } cfg_write_t;

endpackage

//--- hdl/fifo_rd_ctrl.sv
`timescale 1ns/1ns

module fifo_rd_ctrl #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                             rd_clk,
  input  logic                             rd_rst_n,
  input  logic                             rd_en,
  input  logic [ADDR_WIDTH:0]              wr_bin_sync,
  input  logic [fifo_cfg_pkg::LEVEL_W-1:0] aempty_level,
  output logic                             rd_rst_n_sync,
  output logic                             ram_ren,
  output logic [ADDR_WIDTH-1:0]            rd_addr,
  output logic [ADDR_WIDTH:0]              rd_gray,
  output logic                             rd_valid,
  output fifo_status_pkg::rd_status_t      rd_status
);

  import fifo_cfg_pkg::*;

  logic [1:0]          rst_sync;
  logic                rd_accept;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_next;
  logic [ADDR_WIDTH:0] level_next;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rd_rst_n_sync = rst_sync[1];

  assign rd_accept   = rd_en && !rd_status.empty;
  assign rd_bin_next = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_accept};

  // a lagging write pointer makes this level an underestimate, never more
  assign level_next = wr_bin_sync - rd_bin_next;

  always_ff @(posedge rd_clk or negedge rd_rst_n_sync) begin
    if (!rd_rst_n_sync) begin
      rd_bin           <= '0;
      rd_gray          <= '0;
      rd_valid         <= 1'b0;
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
      rd_status.rd_level <= '0;
    end else begin
      rd_bin             <= rd_bin_next;
      rd_gray            <= (rd_bin_next >> 1) ^ rd_bin_next;
      rd_valid           <= rd_accept;
      rd_status.empty    <= level_next == '0;
      rd_status.aempty   <= LEVEL_W'(level_next) <= aempty_level;
      rd_status.rd_level <= LEVEL_W'(level_next);
    end
  end

  assign ram_ren = rd_accept;
  assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

endmodule

//--- hdl/fifo_status_pkg.sv
package fifo_status_pkg;

  // flags and fill level as seen from the write clock domain
  typedef struct packed {
    logic                             full;
    logic                             afull;
    logic [fifo_cfg_pkg::LEVEL_W-1:0] wr_level;
  } wr_status_t;

  // flags and fill level as seen from the read clock domain
  typedef struct packed {
    logic                             empty;
    logic                             aempty;
    logic [fifo_cfg_pkg::LEVEL_W-1:0] rd_level;
  } rd_status_t;

endpackage

//--- hdl/fifo_thresh_regs.sv
`timescale 1ns/1ns

module fifo_thresh_regs #(
  parameter int RST_AFULL  = 14,
  parameter int RST_AEMPTY = 2
) (
  input  logic                             wr_clk,
  input  logic                             wr_rst_n,
  input  fifo_cfg_pkg::cfg_write_t         cfg,
  input  logic                             rd_clk,
  input  logic                             rd_rst_n,
  output logic [fifo_cfg_pkg::LEVEL_W-1:0] afull_level,
  output logic [fifo_cfg_pkg::LEVEL_W-1:0] aempty_level
);

  import fifo_cfg_pkg::*;

  logic [LEVEL_W-1:0] afull_q;
  logic [LEVEL_W-1:0] aempty_q;
  logic [LEVEL_W-1:0] aempty_meta;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      afull_q  <= LEVEL_W'(RST_AFULL);
      aempty_q <= LEVEL_W'(RST_AEMPTY);
    end else if (cfg.wen) begin
      case (cfg.sel)
        CFG_AFULL_LEVEL:  afull_q  <= cfg.value;
        CFG_AEMPTY_LEVEL: aempty_q <= cfg.value;
      endcase
    end
  end

  assign afull_level = afull_q;

  // the almost-empty threshold only changes while the fifo is idle,
  // so a plain two-flop crossing of the whole word is enough
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      aempty_meta  <= LEVEL_W'(RST_AEMPTY);
      aempty_level <= LEVEL_W'(RST_AEMPTY);
    end else begin
      aempty_meta  <= aempty_q;
      aempty_level <= aempty_meta;
    end
  end

endmodule

//--- hdl/fifo_wr_ctrl.sv
`timescale 1ns/1ns

module fifo_wr_ctrl #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                             wr_clk,
  input  logic                             rd_rst_n,
  input  logic                             wr_en,
  input  logic [ADDR_WIDTH:0]              rd_bin_sync,
  input  logic [fifo_cfg_pkg::LEVEL_W-1:0] afull_level,
  output logic                             wr_rst_n,
  output logic                             ram_wen,
  output logic [ADDR_WIDTH-1:0]            wr_addr,
  output logic [ADDR_WIDTH:0]              wr_gray,
  output fifo_status_pkg::wr_status_t      wr_status
);

  import fifo_cfg_pkg::*;

  logic [1:0]          rst_sync;
  logic                wr_accept;
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_next;
  logic [ADDR_WIDTH:0] level_next;

  // assert asynchronously, release on the second wr_clk edge
  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign wr_rst_n = rst_sync[1];

  assign wr_accept   = wr_en && !wr_status.full;
  assign wr_bin_next = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_accept};

  // the synchronized read pointer lags, so this level can only overestimate
  assign level_next = wr_bin_next - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin    <= '0;
      wr_gray   <= '0;
      wr_status <= '0;
    end else begin
      wr_bin             <= wr_bin_next;
      wr_gray            <= (wr_bin_next >> 1) ^ wr_bin_next;
      wr_status.full     <= level_next == {1'b1, {ADDR_WIDTH{1'b0}}};
      wr_status.afull    <= LEVEL_W'(level_next) >= afull_level;
      wr_status.wr_level <= LEVEL_W'(level_next);
    end
  end

  assign ram_wen = wr_accept;
  assign wr_addr = wr_bin[ADDR_WIDTH-1:0];

endmodule

//--- hdl/ptr_sync.sv
`timescale 1ns/1ns

module ptr_sync #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                dst_clk,
  input  logic                dst_rst_n,
  input  logic [ADDR_WIDTH:0] gray_in,
  output logic [ADDR_WIDTH:0] gray_sync,
  output logic [ADDR_WIDTH:0] bin_sync
);

  logic [ADDR_WIDTH:0] gray_meta;

  // only one bit of gray_in changes per source edge, so two flops are safe
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // each binary bit is the xor of all gray bits at and above it
  always_comb begin
    for (int i = 0; i <= ADDR_WIDTH; i++) begin
      bin_sync[i] = ^(gray_sync >> i);
    end
  end

endmodule

//--- project.f
hdl/fifo_cfg_pkg.sv
hdl/fifo_status_pkg.sv
hdl/ptr_sync.sv
hdl/dual_port_ram.sv
hdl/fifo_thresh_regs.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/async_fifo.sv
tests/tb_async_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_async_fifo -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

grep -q "TB FAILED" "$LOG"
grep_status=$?
if [ $grep_status -eq 0 ]; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $grep_status -ne 1 ]; then
  echo "could not search $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

//--- tests/tb_async_fifo.sv
`timescale 1ns/1ns

module tb_async_fifo;

  import fifo_cfg_pkg::*;
  import fifo_status_pkg::*;

  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int TIMEOUT    = 1000;
  localparam int AFULL_SET  = 5;
  localparam int AEMPTY_SET = 3;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b1;
  logic                  rd_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  cfg_write_t            cfg;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  wr_status_t            wr_status;
  rd_status_t            rd_status;

  logic [DATA_WIDTH-1:0] model_q[$];
  int                    seed = 46406;
  int                    pop_count = 0;
  int                    reads_issued = 0;
  int                    pops_before;
  string                 test_name = "reset";

  async_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_dut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .cfg      (cfg),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .wr_status(wr_status),
    .rd_status(rd_status)
  );

  always #4 wr_clk = ~wr_clk;

  // rd_clk starts high, which keeps its falling edges clear of every wr_clk edge
  always #7 rd_clk = ~rd_clk;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      stop_with_error($sformatf("mismatch in %s (%s): expected %0d, actual %0d",
                                test_name, what, expected, actual));
    end
  endtask

  // every word that comes out must be the oldest one the model still holds
  always @(negedge rd_clk) begin
    if (rd_valid) begin
      assert (model_q.size() != 0) else stop_with_error("rd_valid pulsed with no word expected");
      if (model_q.size() != 0) begin
        check_value("rd_data", int'(model_q[0]), int'(rd_data));
        void'(model_q.pop_front());
        pop_count++;
      end
    end
  end

  task automatic settle;
    repeat (4) @(negedge wr_clk);
    repeat (4) @(negedge rd_clk);
  endtask

  task automatic write_word(input logic [DATA_WIDTH-1:0] data);
    int cycles;
    cycles = 0;
    @(negedge wr_clk);
    while (wr_status.full) begin
      wr_en = 1'b0;
      cycles++;
      assert (cycles < TIMEOUT) else stop_with_error("timeout waiting for the FIFO to leave full");
      @(negedge wr_clk);
    end
    wr_en   = 1'b1;
    wr_data = data;
    model_q.push_back(data);
  endtask

  task automatic write_idle(input int n);
    repeat (n) begin
      @(negedge wr_clk);
      wr_en = 1'b0;
    end
  endtask

  // a word offered while full is high never enters the model
  task automatic write_attempt(input logic [DATA_WIDTH-1:0] data);
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = data;
    if (!wr_status.full) begin
      model_q.push_back(data);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic fill_words(input int n);
    for (int i = 0; i < n; i++) begin
      write_word(DATA_WIDTH'($random(seed)));
    end
    write_idle(1);
  endtask

  task automatic random_writes(input int n);
    for (int i = 0; i < n; i++) begin
      write_word(DATA_WIDTH'($random(seed)));
      write_idle($random(seed) & 3);
    end
    write_idle(1);
  endtask

  task automatic read_words(input int n);
    int issued;
    int cycles;
    issued = 0;
    cycles = 0;
    while (issued < n) begin
      @(negedge rd_clk);
      rd_en = !rd_status.empty;
      if (!rd_status.empty) begin
        issued++;
      end
      cycles++;
      assert (cycles < TIMEOUT) else stop_with_error("timeout waiting for data to read");
    end
    reads_issued += n;
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  task automatic random_reads(input int n);
    int issued;
    int cycles;
    issued = 0;
    cycles = 0;
    while (issued < n) begin
      @(negedge rd_clk);
      rd_en = ($random(seed) & 1) != 0;
      if (rd_en && !rd_status.empty) begin
        issued++;
      end
      cycles++;
      assert (cycles < TIMEOUT) else stop_with_error("timeout in the random read stream");
    end
    reads_issued += n;
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  // pop_count only moves on falling rd_clk edges, so it is polled on rising ones
  task automatic wait_for_pops;
    int cycles;
    cycles = 0;
    do begin
      @(posedge rd_clk);
      cycles++;
      assert (cycles < TIMEOUT) else stop_with_error("timeout waiting for rd_valid");
    end while (pop_count < reads_issued);
  endtask

  task automatic write_cfg(input cfg_reg_e sel, input logic [LEVEL_W-1:0] value);
    @(negedge wr_clk);
    cfg.wen   = 1'b1;
    cfg.sel   = sel;
    cfg.value = value;
    @(negedge wr_clk);
    cfg = '0;
  endtask

  task automatic check_levels;
    int depth_now;
    depth_now = model_q.size();
    check_value("wr_level", depth_now, int'(wr_status.wr_level));
    check_value("rd_level", depth_now, int'(rd_status.rd_level));
    check_value("afull", int'(depth_now >= AFULL_SET), int'(wr_status.afull));
    check_value("aempty", int'(depth_now <= AEMPTY_SET), int'(rd_status.aempty));
  endtask

  initial begin
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    cfg      = '0;
    rd_en    = 1'b0;
    repeat (5) @(negedge wr_clk);
    rd_rst_n = 1'b1;
    settle();

    check_value("full", 0, int'(wr_status.full));
    check_value("afull", 0, int'(wr_status.afull));
    check_value("rd_valid", 0, int'(rd_valid));
    check_value("empty", 1, int'(rd_status.empty));
    check_value("aempty", 1, int'(rd_status.aempty));
    check_value("wr_level", 0, int'(wr_status.wr_level));
    check_value("rd_level", 0, int'(rd_status.rd_level));

    test_name = "ordering";
    fork
      random_writes(40);
      random_reads(40);
    join
    wait_for_pops();
    check_value("words left in model", 0, model_q.size());
    settle();

    test_name = "full_and_drop";
    pops_before = pop_count;
    fill_words(FIFO_DEPTH);
    check_value("full", 1, int'(wr_status.full));
    check_value("wr_level", FIFO_DEPTH, int'(wr_status.wr_level));
    write_attempt(8'ha5);
    check_value("full after dropped write", 1, int'(wr_status.full));
    read_words(FIFO_DEPTH);
    wait_for_pops();
    settle();
    check_value("words drained", FIFO_DEPTH, pop_count - pops_before);
    check_value("empty", 1, int'(rd_status.empty));
    check_value("words left in model", 0, model_q.size());

    test_name = "empty_read";
    @(negedge rd_clk);
    check_value("empty", 1, int'(rd_status.empty));
    rd_en = 1'b1;
    // an accepted read would show rd_valid at the very next falling edge
    repeat (3) begin
      @(negedge rd_clk);
      rd_en = 1'b0;
      check_value("rd_valid", 0, int'(rd_valid));
    end

    test_name = "thresholds";
    write_cfg(CFG_AFULL_LEVEL, LEVEL_W'(AFULL_SET));
    write_cfg(CFG_AEMPTY_LEVEL, LEVEL_W'(AEMPTY_SET));
    settle();
    fill_words(4);
    settle();
    check_levels();
    fill_words(1);
    settle();
    check_levels();
    read_words(2);
    wait_for_pops();
    settle();
    check_levels();
    fill_words(1);
    settle();
    check_levels();
    read_words(4);
    wait_for_pops();
    settle();

    if (model_q.size() == 0 && pop_count == reads_issued) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_error("reference queue still holds words at the end of the run");
    end
  end

endmodule
